/* top_level.f */
infer_pkg.sv
piece_ram.sv
piece_gather.sv
data_medium.sv
heap_medium.sv
top_level.sv
top_level_monitor.sv
top_level_checker.sv
tb_top_level.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_top_level
FLIST     ?= top_level.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(filter-out +%,$(shell cat $(FLIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Pass only when the pass line shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx '\*\* PASS \*\*'

clean:
	rm -rf $(OBJ_DIR)

/* tb_top_level.sv */
`timescale 1ns/1ps

module tb_top_level;

  localparam int DATA_ADDRS = 512;
  localparam int HEAP_ADDRS = 128;
  localparam int PIECES     = infer_pkg::DATA_PIECES;
  localparam int LOAD_AW    = $clog2(DATA_ADDRS * PIECES);
  localparam int DATA_AW    = $clog2(DATA_ADDRS);
  localparam int HEAP_AW    = $clog2(HEAP_ADDRS);
  localparam int WAIT_LIMIT = 50;                  // Cycles before a wait gives up

  logic                clk_100mhz;
  logic                reset;
  logic                load_we;
  logic [LOAD_AW-1:0]  load_addr;
  infer_pkg::piece_t   load_piece;
  logic                data_req;
  logic [DATA_AW-1:0]  data_addr;
  logic                data_valid;
  infer_pkg::half_t    data_x;
  infer_pkg::half_t    data_y;
  logic                heap_req;
  logic                heap_we;
  logic [HEAP_AW-1:0]  heap_addr;
  infer_pkg::half_t    heap_wdata;
  logic                heap_done;
  infer_pkg::half_t    heap_rdata;

  logic [31:0]         lcg_state;
  infer_pkg::piece_t   data_model [DATA_ADDRS*PIECES];  // Pieces as loaded
  infer_pkg::half_t    heap_model [HEAP_ADDRS];         // Last word written
  int                  tb_errors;
  int                  tests_run;
  int                  tests_failed;
  int                  errors_before;

  top_level top_level_inst (
    .clk_100mhz (clk_100mhz), .reset (reset),
    .load_we (load_we), .load_addr (load_addr), .load_piece (load_piece),
    .data_req (data_req), .data_addr (data_addr), .data_valid (data_valid),
    .data_x (data_x), .data_y (data_y),
    .heap_req (heap_req), .heap_we (heap_we), .heap_addr (heap_addr),
    .heap_wdata (heap_wdata), .heap_done (heap_done), .heap_rdata (heap_rdata)
  );

  top_level_monitor monitor_inst (
    .clk_100mhz (clk_100mhz), .reset (reset),
    .data_valid (data_valid), .data_x (data_x), .data_y (data_y),
    .heap_done (heap_done), .heap_rdata (heap_rdata)
  );

  initial begin
    clk_100mhz = 1'b0;
    forever #5 clk_100mhz = ~clk_100mhz;           // 100 MHz
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // x is pieces 0-1 of the record, y is pieces 2-3, piece 0 lowest
  function automatic infer_pkg::half_t expected_half(input int rec, input bit upper);
    int base;
    base = rec * PIECES + (upper ? 2 : 0);
    return {data_model[base+1], data_model[base]};
  endfunction

  task automatic give_up(input string what);
    $display("Timeout: %s did not arrive within %0d cycles", what, WAIT_LIMIT);
    $display("** FAIL **");
    $finish;
  endtask

  task automatic finish_test(input string name);
    int errs;
    errs = tb_errors + monitor_inst.error_count - errors_before;
    tests_run++;
    if (errs != 0) tests_failed++;
    $display("test %0d %s: %s (%0d errors)", tests_run, name, errs == 0 ? "ok" : "FAILED", errs);
    errors_before = tb_errors + monitor_inst.error_count;
  endtask

  task automatic check_latency(input string what, input int got, input int want);
    if (got != want) begin
      tb_errors++;
      $display("ERROR at %0t: %s took %0d cycles, expected %0d", $time, what, got, want);
    end
  endtask

  // Counts falling edges since the request edge
  task automatic wait_strobe(input bit on_heap, output int cycles);
    cycles = 1;
    while (!(on_heap ? heap_done : data_valid) && cycles < WAIT_LIMIT) begin
      @(negedge clk_100mhz);
      cycles++;
    end
    if (!(on_heap ? heap_done : data_valid)) give_up(on_heap ? "heap_done" : "data_valid");
  endtask

  task automatic load_record(input int rec);
    for (int k = 0; k < PIECES; k++) begin
      @(negedge clk_100mhz);
      load_we    = 1'b1;
      load_addr  = LOAD_AW'(rec * PIECES + k);
      load_piece = {next_rand(), next_rand()};
      data_model[rec*PIECES+k] = load_piece;
    end
    @(negedge clk_100mhz);
    load_we = 1'b0;
  endtask

  task automatic read_record(input int rec, output int latency);
    @(negedge clk_100mhz);
    data_req  = 1'b1;
    data_addr = DATA_AW'(rec);
    monitor_inst.expect_data(expected_half(rec, 1'b0), expected_half(rec, 1'b1));
    @(negedge clk_100mhz);
    data_req = 1'b0;
    wait_strobe(1'b0, latency);
  endtask

  task automatic heap_access(input bit write, input int addr, input infer_pkg::half_t wdata,
                             output int latency);
    @(negedge clk_100mhz);
    heap_req   = 1'b1;
    heap_we    = write;
    heap_addr  = HEAP_AW'(addr);
    heap_wdata = wdata;
    if (write) heap_model[addr] = wdata;
    monitor_inst.expect_heap(!write, heap_model[addr]);
    @(negedge clk_100mhz);
    heap_req = 1'b0;
    heap_we  = 1'b0;
    wait_strobe(1'b1, latency);
  endtask

  initial begin
    int               recs [16];
    int               order [8];
    infer_pkg::half_t word;
    int               lat;
    int               j;
    int               tmp;
    int               cycles;
    bit               seen_data;
    bit               seen_heap;

    lcg_state     = 32'hc142;
    tb_errors     = 0;
    tests_run     = 0;
    tests_failed  = 0;
    errors_before = 0;
    reset         = 1'b1;
    load_we       = 1'b0;
    load_addr     = '0;
    load_piece    = '0;
    data_req      = 1'b0;
    data_addr     = '0;
    heap_req      = 1'b0;
    heap_we       = 1'b0;
    heap_addr     = '0;
    heap_wdata    = '0;
    repeat (16) @(negedge clk_100mhz);
    reset = 1'b0;

    for (int i = 0; i < 20; i++) begin             // No requests, no strobes
      @(negedge clk_100mhz);
      if (data_valid || heap_done) begin
        tb_errors++;
        $display("ERROR at %0t: strobe while idle after reset", $time);
      end
    end
    finish_test("idle after reset");

    for (int i = 0; i < 16; i++) begin
      recs[i] = int'(next_rand() >> 16) % DATA_ADDRS;
      load_record(recs[i]);
    end
    for (int i = 0; i < 16; i++) begin
      read_record(recs[i], lat);
      check_latency("data read", lat, 7);
    end
    finish_test("load and read records");

    for (int i = 0; i < 8; i++) begin
      order[i] = int'(next_rand() >> 16) % HEAP_ADDRS;
      word     = {next_rand(), next_rand(), next_rand(), next_rand()};
      heap_access(1'b1, order[i], word, lat);
      check_latency("heap write", lat, 3);
    end
    for (int i = 7; i > 0; i--) begin              // Shuffle the read order
      j        = int'(next_rand() >> 16) % (i + 1);
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (int i = 0; i < 8; i++) begin
      heap_access(1'b0, order[i], '0, lat);
      check_latency("heap read", lat, 5);
    end
    finish_test("heap write and shuffled read");

    read_record(recs[0], lat);
    check_latency("data read", lat, 7);
    heap_access(1'b0, order[0], '0, lat);
    check_latency("heap read", lat, 5);
    finish_test("fixed latencies");

    @(negedge clk_100mhz);
    data_req  = 1'b1;
    data_addr = DATA_AW'(recs[1]);
    monitor_inst.expect_data(expected_half(recs[1], 1'b0), expected_half(recs[1], 1'b1));
    @(negedge clk_100mhz);
    data_req = 1'b0;
    @(negedge clk_100mhz);
    data_req  = 1'b1;                              // Lands while busy
    data_addr = DATA_AW'(recs[2]);
    @(negedge clk_100mhz);
    data_req = 1'b0;
    wait_strobe(1'b0, lat);
    repeat (15) @(negedge clk_100mhz);             // Monitor flags any extra strobe
    finish_test("request while busy dropped");

    word = {next_rand(), next_rand(), next_rand(), next_rand()};
    @(negedge clk_100mhz);
    data_req   = 1'b1;
    data_addr  = DATA_AW'(recs[3]);
    heap_req   = 1'b1;
    heap_we    = 1'b1;
    heap_addr  = HEAP_AW'(order[1]);
    heap_wdata = word;
    heap_model[order[1]] = word;
    monitor_inst.expect_data(expected_half(recs[3], 1'b0), expected_half(recs[3], 1'b1));
    monitor_inst.expect_heap(1'b0, word);
    @(negedge clk_100mhz);
    data_req  = 1'b0;
    heap_req  = 1'b0;
    heap_we   = 1'b0;
    seen_data = data_valid;
    seen_heap = heap_done;
    cycles    = 1;
    while (!(seen_data && seen_heap) && cycles < WAIT_LIMIT) begin
      @(negedge clk_100mhz);
      cycles++;
      seen_data |= data_valid;
      seen_heap |= heap_done;
    end
    if (!(seen_data && seen_heap)) give_up("data_valid and heap_done together");
    heap_access(1'b0, order[1], '0, lat);          // Confirm the concurrent write
    finish_test("heap write with data read");

    repeat (5) @(negedge clk_100mhz);
    if (monitor_inst.pending() != 0) begin
      tb_errors++;
      $display("%0d expected results never arrived", monitor_inst.pending());
    end
    $display("tests run %0d, failed %0d, errors %0d",
             tests_run, tests_failed, tb_errors + monitor_inst.error_count);
    if (tests_failed == 0 && tb_errors + monitor_inst.error_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* top_level_checker.sv */
`timescale 1ns/1ps

module top_level_checker (
  input logic clk_100mhz,
  input logic reset,
  input logic data_req,
  input logic data_valid,
  input logic heap_req,
  input logic heap_we,
  input logic heap_done
);

  logic data_busy;                                 // Mirrors the data medium
  logic heap_busy;                                 // Mirrors the heap medium

  // Requests are accepted only while idle
  always_ff @(posedge clk_100mhz) begin
    if (reset) begin
      data_busy <= 1'b0;
      heap_busy <= 1'b0;
    end else begin
      if (data_req && !data_busy) data_busy <= 1'b1;
      else if (data_valid) data_busy <= 1'b0;
      if (heap_req && !heap_busy) heap_busy <= 1'b1;
      else if (heap_done) heap_busy <= 1'b0;
    end
  end

  reset_quiet: assert property (@(posedge clk_100mhz)
    reset |=> (!data_valid && !heap_done))
    else $error("strobe seen during or right after reset");

  data_latency: assert property (@(posedge clk_100mhz) disable iff (reset)
    (data_req && !data_busy) |-> ##7 data_valid)
    else $error("data_valid not 7 cycles after accepted request");

  heap_write_latency: assert property (@(posedge clk_100mhz) disable iff (reset)
    (heap_req && !heap_busy && heap_we) |-> ##3 heap_done)
    else $error("heap_done not 3 cycles after accepted write");

  heap_read_latency: assert property (@(posedge clk_100mhz) disable iff (reset)
    (heap_req && !heap_busy && !heap_we) |-> ##5 heap_done)
    else $error("heap_done not 5 cycles after accepted read");

endmodule

bind top_level top_level_checker checker_inst (
  .clk_100mhz (clk_100mhz),
  .reset      (reset),
  .data_req   (data_req),
  .data_valid (data_valid),
  .heap_req   (heap_req),
  .heap_we    (heap_we),
  .heap_done  (heap_done)
);

/* top_level_monitor.sv */
`timescale 1ns/1ps

module top_level_monitor (
  input logic             clk_100mhz,
  input logic             reset,
  input logic             data_valid,
  input infer_pkg::half_t data_x,
  input infer_pkg::half_t data_y,
  input logic             heap_done,
  input infer_pkg::half_t heap_rdata
);

  infer_pkg::half_t data_x_q [$];                  // Expected x per request
  infer_pkg::half_t data_y_q [$];
  infer_pkg::half_t heap_q [$];                    // Expected heap word
  bit               heap_read_q [$];               // Only reads carry data
  infer_pkg::half_t exp_x;
  infer_pkg::half_t exp_y;
  infer_pkg::half_t exp_word;
  bit               exp_read;
  int               error_count = 0;

  function void expect_data(input infer_pkg::half_t x, input infer_pkg::half_t y);
    data_x_q.push_back(x);
    data_y_q.push_back(y);
  endfunction

  function void expect_heap(input bit is_read, input infer_pkg::half_t word);
    heap_read_q.push_back(is_read);
    heap_q.push_back(word);
  endfunction

  function int pending();
    return data_x_q.size() + heap_q.size();        // Results still owed
  endfunction

  // Outputs settle after the rising edge, so look on the falling one
  always @(negedge clk_100mhz) begin
    if (!reset && data_valid) begin
      if (data_x_q.size() == 0) begin
        error_count++;
        $display("ERROR at %0t: data_valid with no request outstanding", $time);
      end else begin
        exp_x = data_x_q.pop_front();
        exp_y = data_y_q.pop_front();
        if (data_x !== exp_x || data_y !== exp_y) begin
          error_count++;
          $display("ERROR at %0t: data x %h y %h, expected x %h y %h",
                   $time, data_x, data_y, exp_x, exp_y);
        end
      end
    end
    if (!reset && heap_done) begin
      if (heap_q.size() == 0) begin
        error_count++;
        $display("ERROR at %0t: heap_done with no request outstanding", $time);
      end else begin
        exp_read = heap_read_q.pop_front();
        exp_word = heap_q.pop_front();
        if (exp_read && heap_rdata !== exp_word) begin
          error_count++;
          $display("ERROR at %0t: heap_rdata %h, expected %h", $time, heap_rdata, exp_word);
        end
      end
    end
  end

endmodule

/* top_level.sv */
`timescale 1ns/1ps

module top_level #(
  parameter int DATA_ADDRS = 512,
  parameter int HEAP_ADDRS = 128
) (
  input  logic                                                clk_100mhz,
  input  logic                                                reset,
  // Host load port
  input  logic                                                load_we,
  input  logic [$clog2(DATA_ADDRS*infer_pkg::DATA_PIECES)-1:0] load_addr,
  input  infer_pkg::piece_t                                   load_piece,
  // Data read port
  input  logic                                                data_req,
  input  logic [$clog2(DATA_ADDRS)-1:0]                       data_addr,
  output logic                                                data_valid,
  output infer_pkg::half_t                                    data_x,
  output infer_pkg::half_t                                    data_y,
  // Heap port
  input  logic                                                heap_req,
  input  logic                                                heap_we,
  input  logic [$clog2(HEAP_ADDRS)-1:0]                       heap_addr,
  input  infer_pkg::half_t                                    heap_wdata,
  output logic                                                heap_done,
  output infer_pkg::half_t                                    heap_rdata
);

  localparam int DATA_DEPTH = DATA_ADDRS * infer_pkg::DATA_PIECES;  // 2048 pieces
  localparam int HEAP_DEPTH = HEAP_ADDRS * infer_pkg::HEAP_PIECES;  // 256 pieces

  // Data medium to data RAM
  logic                          data_ram_re;
  logic [$clog2(DATA_DEPTH)-1:0] data_ram_raddr;
  infer_pkg::piece_t             data_ram_rdata;

  // Heap medium to heap RAM
  logic                          heap_ram_we;
  logic [$clog2(HEAP_DEPTH)-1:0] heap_ram_waddr;
  infer_pkg::piece_t             heap_ram_wdata;
  logic                          heap_ram_re;
  logic [$clog2(HEAP_DEPTH)-1:0] heap_ram_raddr;
  infer_pkg::piece_t             heap_ram_rdata;

  data_medium #(
    .DATA_ADDRS (DATA_ADDRS)
  ) data_medium_inst (
    .clk_100mhz (clk_100mhz),
    .reset      (reset),
    .req        (data_req),
    .addr       (data_addr),
    .ram_rdata  (data_ram_rdata),
    .valid      (data_valid),
    .x          (data_x),
    .y          (data_y),
    .ram_re     (data_ram_re),
    .ram_raddr  (data_ram_raddr)
  );

  // Host writes, medium reads
  piece_ram #(
    .DEPTH (DATA_DEPTH)
  ) data_ram (
    .clk_100mhz (clk_100mhz),
    .we         (load_we),
    .waddr      (load_addr),
    .wdata      (load_piece),
    .re         (data_ram_re),
    .raddr      (data_ram_raddr),
    .rdata      (data_ram_rdata)
  );

  heap_medium #(
    .HEAP_ADDRS (HEAP_ADDRS)
  ) heap_medium_inst (
    .clk_100mhz (clk_100mhz),
    .reset      (reset),
    .req        (heap_req),
    .we         (heap_we),
    .addr       (heap_addr),
    .wdata      (heap_wdata),
    .ram_rdata  (heap_ram_rdata),
    .done       (heap_done),
    .rdata      (heap_rdata),
    .ram_we     (heap_ram_we),
    .ram_waddr  (heap_ram_waddr),
    .ram_wdata  (heap_ram_wdata),
    .ram_re     (heap_ram_re),
    .ram_raddr  (heap_ram_raddr)
  );

  // Both ports owned by the heap medium
  piece_ram #(
    .DEPTH (HEAP_DEPTH)
  ) heap_ram (
    .clk_100mhz (clk_100mhz),
    .we         (heap_ram_we),
    .waddr      (heap_ram_waddr),
    .wdata      (heap_ram_wdata),
    .re         (heap_ram_re),
    .raddr      (heap_ram_raddr),
    .rdata      (heap_ram_rdata)
  );

endmodule

/* heap_medium.sv */
`timescale 1ns/1ps

module heap_medium #(
  parameter int HEAP_ADDRS = 128
) (
  input  logic                                               clk_100mhz,
  input  logic                                               reset,
  input  logic                                               req,      // Operation strobe
  input  logic                                               we,       // High for a write
  input  logic [$clog2(HEAP_ADDRS)-1:0]                      addr,
  input  infer_pkg::half_t                                   wdata,
  input  infer_pkg::piece_t                                  ram_rdata,
  output logic                                               done,     // Write or read finished
  output infer_pkg::half_t                                   rdata,
  output logic                                               ram_we,
  output logic [$clog2(HEAP_ADDRS*infer_pkg::HEAP_PIECES)-1:0] ram_waddr,
  output infer_pkg::piece_t                                  ram_wdata,
  output logic                                               ram_re,
  output logic [$clog2(HEAP_ADDRS*infer_pkg::HEAP_PIECES)-1:0] ram_raddr
);

  localparam int PIECES = infer_pkg::HEAP_PIECES;
  localparam int RAM_AW = $clog2(HEAP_ADDRS * PIECES);
  localparam int CNT_W  = (PIECES > 1) ? $clog2(PIECES) : 1;
  localparam int LAT    = infer_pkg::RAM_LATENCY;

  logic               busy;                        // Operation in flight
  logic               active;                      // Walking the pieces
  logic               we_q;                        // Latched operation
  logic [CNT_W-1:0]   cnt;
  logic               wr_done;                     // Last piece written
  logic               rd_valid;                    // Gathered word ready
  logic [LAT-1:0]     re_pipe;
  logic [RAM_AW-1:0]  addr_q;                      // Shared piece address
  infer_pkg::half_t   wdata_q;                     // Shifts down one piece per write

  always_ff @(posedge clk_100mhz) begin
    if (reset) begin
      busy    <= 1'b0;
      active  <= 1'b0;
      we_q    <= 1'b0;
      cnt     <= '0;
      wr_done <= 1'b0;
      re_pipe <= '0;
    end else begin
      wr_done <= 1'b0;
      re_pipe <= {re_pipe[LAT-2:0], ram_re};
      if (req && !busy) begin
        busy   <= 1'b1;                            // Drop anything until done
        active <= 1'b1;
        we_q   <= we;
        cnt    <= '0;
      end else begin
        if (done) busy <= 1'b0;
        if (active) begin
          cnt <= cnt + 1'b1;
          if (cnt == CNT_W'(PIECES - 1)) begin
            active  <= 1'b0;
            wr_done <= we_q;                       // Reads finish through the gatherer
          end
        end
      end
    end
  end

  // Address and write word
  always_ff @(posedge clk_100mhz) begin
    if (req && !busy) begin
      addr_q  <= RAM_AW'(addr) * RAM_AW'(PIECES);
      wdata_q <= wdata;
    end else if (active) begin
      addr_q  <= addr_q + 1'b1;
      wdata_q <= wdata_q >> infer_pkg::PIECE_WIDTH;  // Next slice to the bottom
    end
  end

  assign ram_we    = active && we_q;
  assign ram_re    = active && !we_q;
  assign ram_waddr = addr_q;
  assign ram_raddr = addr_q;
  assign ram_wdata = wdata_q[infer_pkg::PIECE_WIDTH-1:0];

  piece_gather #(
    .word_t (infer_pkg::half_t),
    .PIECES (PIECES)
  ) gather_inst (
    .clk_100mhz  (clk_100mhz),
    .reset       (reset),
    .piece_valid (re_pipe[LAT-1]),
    .piece       (ram_rdata),
    .word_valid  (rd_valid),
    .word        (rdata)
  );

  assign done = wr_done || rd_valid;               // Cycle 3 on write, 5 on read

endmodule

/* data_medium.sv */
`timescale 1ns/1ps

module data_medium #(
  parameter int DATA_ADDRS = 512
) (
  input  logic                                              clk_100mhz,
  input  logic                                              reset,
  input  logic                                              req,       // Read strobe
  input  logic [$clog2(DATA_ADDRS)-1:0]                     addr,      // Record index
  input  infer_pkg::piece_t                                 ram_rdata,
  output logic                                              valid,     // Record strobe
  output infer_pkg::half_t                                  x,
  output infer_pkg::half_t                                  y,
  output logic                                              ram_re,
  output logic [$clog2(DATA_ADDRS*infer_pkg::DATA_PIECES)-1:0] ram_raddr
);

  localparam int PIECES = infer_pkg::DATA_PIECES;
  localparam int RAM_AW = $clog2(DATA_ADDRS * PIECES);
  localparam int CNT_W  = $clog2(PIECES);
  localparam int LAT    = infer_pkg::RAM_LATENCY;

  logic                   busy;                    // Request in flight
  logic                   issuing;                 // Piece addresses going out
  logic [CNT_W-1:0]       cnt;                     // Piece being addressed
  logic [RAM_AW-1:0]      raddr_q;
  logic [LAT-1:0]         re_pipe;                 // Matches RAM latency
  infer_pkg::data_record_t record;

  // Busy flag and address walk
  always_ff @(posedge clk_100mhz) begin
    if (reset) begin
      busy    <= 1'b0;
      issuing <= 1'b0;
      cnt     <= '0;
      re_pipe <= '0;
    end else begin
      re_pipe <= {re_pipe[LAT-2:0], ram_re};
      if (req && !busy) begin
        busy    <= 1'b1;                           // Later requests dropped
        issuing <= 1'b1;
        cnt     <= '0;
      end else begin
        if (valid) busy <= 1'b0;
        if (issuing) begin
          cnt <= cnt + 1'b1;
          if (cnt == CNT_W'(PIECES - 1)) issuing <= 1'b0;  // Last piece sent
        end
      end
    end
  end

  // First piece address is record times PIECES
  always_ff @(posedge clk_100mhz) begin
    if (req && !busy) raddr_q <= RAM_AW'(addr) * RAM_AW'(PIECES);
    else if (issuing) raddr_q <= raddr_q + 1'b1;
  end

  assign ram_re    = issuing;
  assign ram_raddr = raddr_q;

  piece_gather #(
    .word_t (infer_pkg::data_record_t),
    .PIECES (PIECES)
  ) gather_inst (
    .clk_100mhz  (clk_100mhz),
    .reset       (reset),
    .piece_valid (re_pipe[LAT-1]),                 // RAM data now valid
    .piece       (ram_rdata),
    .word_valid  (valid),
    .word        (record)
  );

  assign x = record.x;                             // Pieces 0 and 1
  assign y = record.y;                             // Pieces 2 and 3

endmodule

/* piece_gather.sv */
`timescale 1ns/1ps

module piece_gather #(
  parameter type word_t = infer_pkg::half_t,
  parameter int  PIECES = infer_pkg::HEAP_PIECES
) (
  input  logic              clk_100mhz,
  input  logic              reset,
  input  logic              piece_valid,           // RAM data is a real piece
  input  infer_pkg::piece_t piece,
  output logic              word_valid,            // One cycle after last piece
  output word_t             word
);

  localparam int WORD_WIDTH = $bits(word_t);
  localparam int CNT_W      = (PIECES > 1) ? $clog2(PIECES) : 1;

  logic [WORD_WIDTH-1:0] shift_q;                  // Fills from the top
  logic [CNT_W-1:0]      cnt;                      // Pieces taken so far

  // Newest piece enters at the top, piece 0 ends at the bottom
  always_ff @(posedge clk_100mhz) begin
    if (piece_valid) begin
      shift_q <= {piece, shift_q[WORD_WIDTH-1:infer_pkg::PIECE_WIDTH]};
    end
  end

  // Position counter and word strobe
  always_ff @(posedge clk_100mhz) begin
    if (reset) begin
      cnt        <= '0;
      word_valid <= 1'b0;
    end else begin
      word_valid <= 1'b0;                          // Strobe for one cycle
      if (piece_valid) begin
        if (cnt == CNT_W'(PIECES - 1)) begin
          cnt        <= '0;                        // Ready for the next word
          word_valid <= 1'b1;
        end else begin
          cnt <= cnt + 1'b1;
        end
      end
    end
  end

  assign word = word_t'(shift_q);                  // Reinterpret as payload

endmodule

/* piece_ram.sv */
`timescale 1ns/1ps

module piece_ram #(
  parameter int DEPTH = 2048
) (
  input  logic                         clk_100mhz,
  input  logic                         we,         // Write strobe
  input  logic [$clog2(DEPTH)-1:0]     waddr,
  input  infer_pkg::piece_t            wdata,
  input  logic                         re,         // Read strobe
  input  logic [$clog2(DEPTH)-1:0]     raddr,
  output infer_pkg::piece_t            rdata       // Valid two cycles after raddr
);

  infer_pkg::piece_t mem [DEPTH];                  // Piece storage
  infer_pkg::piece_t read_q;                       // Array read stage

  // Write port
  always_ff @(posedge clk_100mhz) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Old contents win on a same-address collision
  always_ff @(posedge clk_100mhz) begin
    if (re) begin
      read_q <= mem[raddr];
    end
  end

  // Output register as in high-performance mode
  always_ff @(posedge clk_100mhz) begin
    rdata <= read_q;
  end

endmodule

/* infer_pkg.sv */
package infer_pkg;

  // BRAM geometry
  localparam int PIECE_WIDTH = 64;                   // Width of one BRAM word
  localparam int HALF_WIDTH  = 2 * PIECE_WIDTH;      // One x or y value, one heap word

  // Piece counts per wide word
  localparam int DATA_PIECES = 4;                    // x pieces then y pieces
  localparam int HEAP_PIECES = HALF_WIDTH / PIECE_WIDTH;

  // Cycles from address to data through the read stage and output register
  localparam int RAM_LATENCY = 2;

  // One BRAM word
  typedef logic [PIECE_WIDTH-1:0] piece_t;

  // x, y and heap word share this width
  typedef logic [HALF_WIDTH-1:0] half_t;

  // Piece k sits at bits 64k+63 down to 64k, so x is pieces 0-1
  typedef struct packed {
    half_t y;                                        // Pieces 2 and 3
    half_t x;                                        // Pieces 0 and 1
  } data_record_t;

endpackage
